//--- Bender.yml
package:
  name: pss_detector

sources:
  - include_dirs:
      - source
    files:
      - source/pss_pkg.sv
      - source/peak_detector.sv
      - source/nid2_decision_fsm.sv
      - source/detection_counters.sv
      - source/sync_fifo.sv
      - source/pss_detector.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/pss_detector_assertions.sv
      - test/tb_pss_detector.sv

//--- filelist.f
+incdir+source
source/pss_pkg.sv
source/peak_detector.sv
source/nid2_decision_fsm.sv
source/detection_counters.sv
source/sync_fifo.sv
source/pss_detector.sv
test/pss_detector_assertions.sv
test/tb_pss_detector.sv

//--- source/detection_counters.sv
`timescale 1ns/10ps
`include "pss_params.svh"

module detection_counters (
    input  logic                     clk_i,
    input  logic                     reset_ni,
    input  logic                     reset_int_n,
    input  logic                     decision_valid_i,
    input  logic                     peak0_i,
    input  logic                     peak1_i,
    input  logic                     peak2_i,
    input  logic                     peak_valid_i,
    output logic                     keep_o,
    output logic [`PSS_COUNT_DW-1:0] peak_count0_o,
    output logic [`PSS_COUNT_DW-1:0] peak_count1_o,
    output logic [`PSS_COUNT_DW-1:0] peak_count2_o
);

    localparam int WARM_DW = $clog2(`PSS_WARMUP_LEN + 1);

    logic [WARM_DW-1:0]       warm_cnt_q;
    logic                     warm_done;
    logic [2:0]               peak_flags;
    logic [`PSS_COUNT_DW-1:0] peak_cnt_q [3];

    // ------------------------------
    // warm-up gate
    // ------------------------------
    assign warm_done = warm_cnt_q == WARM_DW'(`PSS_WARMUP_LEN);

    always_ff @(posedge clk_i) begin
        if (!reset_int_n) begin
            warm_cnt_q <= '0;
            keep_o <= 1'b0;
        end else begin
            keep_o <= decision_valid_i && warm_done;
            // saturates once warm-up is over
            if (decision_valid_i && !warm_done) begin
                warm_cnt_q <= warm_cnt_q + 1'b1;
            end
        end
    end

    // ------------------------------
    // peak counters
    // ------------------------------
    assign peak_flags = {peak2_i, peak1_i, peak0_i};

    // survive clear_ni, only a full reset zeroes them
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int i = 0; i < 3; i++) begin
                peak_cnt_q[i] <= '0;
            end
        end else if (peak_valid_i) begin
            for (int i = 0; i < 3; i++) begin
                if (peak_flags[i]) begin
                    peak_cnt_q[i] <= peak_cnt_q[i] + 1'b1;
                end
            end
        end
    end

    assign peak_count0_o = peak_cnt_q[0];
    assign peak_count1_o = peak_cnt_q[1];
    assign peak_count2_o = peak_cnt_q[2];

endmodule

//--- source/nid2_decision_fsm.sv
`timescale 1ns/10ps

module nid2_decision_fsm (
    input  logic            clk_i,
    input  logic            reset_int_n,
    input  pss_pkg::mode_t  mode_i,
    input  pss_pkg::nid2_t  requested_n_id_2_i,
    input  logic            peak0_i,
    input  logic            peak1_i,
    input  logic            peak2_i,
    input  logic            peak_valid_i,
    output logic            corr_en_o,
    output logic            decision_valid_o,
    output pss_pkg::nid2_t  nid2_o,
    output logic            hit_o
);

    logic [2:0]     peaks;
    logic           unique_peak;
    pss_pkg::nid2_t peak_idx;
    logic           hit;

    assign peaks = {peak2_i, peak1_i, peak0_i};

    // a decision needs exactly one correlator reporting a peak
    always_comb begin
        unique_peak = 1'b1;
        case (peaks)
            3'b001: peak_idx = 2'd0;
            3'b010: peak_idx = 2'd1;
            3'b100: peak_idx = 2'd2;
            default: begin
                peak_idx = 2'd0;
                unique_peak = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (mode_i)
            pss_pkg::MODE_SEARCH: hit = unique_peak;
            pss_pkg::MODE_FIND: hit = unique_peak && (peak_idx == requested_n_id_2_i);
            // pause and the unused code
            default: hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_int_n) begin
            corr_en_o <= 1'b0;
            decision_valid_o <= 1'b0;
            hit_o <= 1'b0;
        end else begin
            corr_en_o <= (mode_i == pss_pkg::MODE_SEARCH) || (mode_i == pss_pkg::MODE_FIND);
            decision_valid_o <= peak_valid_i;
            if (peak_valid_i) begin
                hit_o <= hit;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (peak_valid_i) begin
            nid2_o <= peak_idx;
        end
    end

endmodule

//--- source/peak_detector.sv
`timescale 1ns/10ps
`include "pss_params.svh"

module peak_detector (
    input  logic               clk_i,
    input  logic               reset_int_n,
    input  pss_pkg::corr_mag_t corr_i,
    input  logic               corr_valid_i,
    input  logic               enable_i,
    input  pss_pkg::corr_mag_t noise_limit_i,
    input  logic [2:0]         detection_shift_i,
    output logic               peak_o,
    output logic               peak_valid_o
);

    localparam int CORR_DW = `PSS_CORR_DW;
    localparam int SUM_DW = CORR_DW + `PSS_WINDOW_LOG2;
    // headroom for the largest detection shift
    localparam int SHIFT_HEAD = 7;
    localparam int THR_DW = CORR_DW + SHIFT_HEAD;

    pss_pkg::corr_mag_t window_q [`PSS_WINDOW_LEN];
    logic [SUM_DW-1:0]  sum_q;
    pss_pkg::corr_mag_t average;
    logic [THR_DW-1:0]  threshold;
    logic               above_noise;
    logic               above_avg;

    // upper bits of the sum are the sum divided by the window length
    assign average = sum_q[SUM_DW-1 -: CORR_DW];
    assign threshold = {{SHIFT_HEAD{1'b0}}, average} << detection_shift_i;

    assign above_noise = corr_i > noise_limit_i;
    assign above_avg = {{SHIFT_HEAD{1'b0}}, corr_i} > threshold;

    always_ff @(posedge clk_i) begin
        if (!reset_int_n) begin
            for (int i = 0; i < `PSS_WINDOW_LEN; i++) begin
                window_q[i] <= '0;
            end
            sum_q <= '0;
            peak_o <= 1'b0;
            peak_valid_o <= 1'b0;
        end else begin
            peak_valid_o <= corr_valid_i;
            if (corr_valid_i) begin
                // compare against the older values, then slide the window
                peak_o <= enable_i && above_noise && above_avg;
                window_q[0] <= corr_i;
                for (int i = 1; i < `PSS_WINDOW_LEN; i++) begin
                    window_q[i] <= window_q[i-1];
                end
                sum_q <= sum_q + corr_i - window_q[`PSS_WINDOW_LEN-1];
            end
        end
    end

endmodule

//--- source/pss_detector.sv
`timescale 1ns/10ps
`include "pss_params.svh"

module pss_detector (
    input  logic                     clk_i,
    input  logic                     reset_ni,
    input  logic                     clear_ni,
    input  pss_pkg::sample_t         sample_i,
    input  logic                     sample_valid_i,
    input  pss_pkg::corr_mag_t       corr0_i,
    input  pss_pkg::corr_mag_t       corr1_i,
    input  pss_pkg::corr_mag_t       corr2_i,
    input  logic                     corr_valid_i,
    input  pss_pkg::mode_t           mode_i,
    input  pss_pkg::nid2_t           requested_n_id_2_i,
    input  pss_pkg::corr_mag_t       noise_limit_i,
    input  logic [2:0]               detection_shift_i,
    output pss_pkg::sample_t         m_data_o,
    output logic                     m_valid_o,
    output pss_pkg::nid2_t           n_id_2_o,
    output logic                     n_id_2_valid_o,
    output logic [`PSS_COUNT_DW-1:0] peak_count0_o,
    output logic [`PSS_COUNT_DW-1:0] peak_count1_o,
    output logic [`PSS_COUNT_DW-1:0] peak_count2_o
);

    logic                 reset_int_n;
    pss_pkg::corr_mag_t   corr_in [3];
    logic [2:0]           peak;
    logic [2:0]           peak_valid;
    logic                 all_valid;
    logic                 corr_en;
    logic                 dec_valid;
    pss_pkg::nid2_t       dec_nid2;
    logic                 dec_hit;
    logic                 keep;
    pss_pkg::peak_entry_t entry_q;
    pss_pkg::peak_entry_t entry_out;
    logic                 sample_empty;
    logic                 sample_full;
    logic                 entry_empty;
    logic                 entry_full;
    logic                 sample_pop;
    logic                 entry_pop;

    // clear_ni restarts detection but leaves the peak counters alone
    assign reset_int_n = reset_ni && clear_ni;

    // ------------------------------
    // peak detection and decision
    // ------------------------------
    assign corr_in[0] = corr0_i;
    assign corr_in[1] = corr1_i;
    assign corr_in[2] = corr2_i;

    for (genvar i = 0; i < 3; i++) begin : gen_peak
        peak_detector i_peak_detector (
            .clk_i             (clk_i),
            .reset_int_n       (reset_int_n),
            .corr_i            (corr_in[i]),
            .corr_valid_i      (corr_valid_i),
            .enable_i          (corr_en),
            .noise_limit_i     (noise_limit_i),
            .detection_shift_i (detection_shift_i),
            .peak_o            (peak[i]),
            .peak_valid_o      (peak_valid[i])
        );
    end

    // the three detectors run in lockstep
    assign all_valid = &peak_valid;

    nid2_decision_fsm i_nid2_decision_fsm (
        .clk_i              (clk_i),
        .reset_int_n        (reset_int_n),
        .mode_i             (mode_i),
        .requested_n_id_2_i (requested_n_id_2_i),
        .peak0_i            (peak[0]),
        .peak1_i            (peak[1]),
        .peak2_i            (peak[2]),
        .peak_valid_i       (all_valid),
        .corr_en_o          (corr_en),
        .decision_valid_o   (dec_valid),
        .nid2_o             (dec_nid2),
        .hit_o              (dec_hit)
    );

    detection_counters i_detection_counters (
        .clk_i            (clk_i),
        .reset_ni         (reset_ni),
        .reset_int_n      (reset_int_n),
        .decision_valid_i (dec_valid),
        .peak0_i          (peak[0]),
        .peak1_i          (peak[1]),
        .peak2_i          (peak[2]),
        .peak_valid_i     (all_valid),
        .keep_o           (keep),
        .peak_count0_o    (peak_count0_o),
        .peak_count1_o    (peak_count1_o),
        .peak_count2_o    (peak_count2_o)
    );

    // entry lines up with keep, which comes a cycle after the decision
    always_ff @(posedge clk_i) begin
        entry_q.nid2 <= dec_nid2;
        entry_q.hit <= dec_hit;
    end

    // ------------------------------
    // output FIFOs
    // ------------------------------
    sync_fifo #(
        .payload_t (pss_pkg::sample_t)
    ) i_sample_fifo (
        .clk_i       (clk_i),
        .reset_int_n (reset_int_n),
        .push_i      (sample_valid_i),
        .data_i      (sample_i),
        .pop_i       (sample_pop),
        .data_o      (m_data_o),
        .empty_o     (sample_empty),
        .full_o      (sample_full)
    );

    sync_fifo #(
        .payload_t (pss_pkg::peak_entry_t)
    ) i_entry_fifo (
        .clk_i       (clk_i),
        .reset_int_n (reset_int_n),
        .push_i      (keep),
        .data_i      (entry_q),
        .pop_i       (entry_pop),
        .data_o      (entry_out),
        .empty_o     (entry_empty),
        .full_o      (entry_full)
    );

    // rate 1: one decision may leave with each sample
    assign sample_pop = !sample_empty;
    assign entry_pop = sample_pop && !entry_empty;

    assign m_valid_o = sample_pop;
    assign n_id_2_valid_o = entry_pop && entry_out.hit;
    assign n_id_2_o = entry_out.nid2;

endmodule

//--- source/pss_params.svh
`ifndef PSS_PARAMS_SVH
`define PSS_PARAMS_SVH

// ------------------------------
// data widths
// ------------------------------
// one I/Q sample, 16 bit real and 16 bit imaginary
`define PSS_SAMPLE_DW 32
`define PSS_CORR_DW 16
`define PSS_COUNT_DW 32

// ------------------------------
// detection
// ------------------------------
// average window, LOG2 must match LEN
`define PSS_WINDOW_LEN 8
`define PSS_WINDOW_LOG2 3
// decisions dropped after reset or clear
`define PSS_WARMUP_LEN 8

// entries per FIFO, power of two
`define PSS_FIFO_DEPTH 32

`endif

//--- source/pss_pkg.sv
`include "pss_params.svh"

package pss_pkg;

    typedef logic [`PSS_SAMPLE_DW-1:0] sample_t;
    typedef logic [`PSS_CORR_DW-1:0] corr_mag_t;

    // value 3 is not listed and falls back to pause
    typedef enum logic [1:0] {
        MODE_SEARCH = 2'd0,
        MODE_FIND   = 2'd1,
        MODE_PAUSE  = 2'd2
    } mode_t;

    typedef logic [1:0] nid2_t;

    // one decision as it sits in the decision FIFO
    typedef struct packed {
        nid2_t nid2;
        logic  hit;
    } peak_entry_t;

endpackage

//--- source/sync_fifo.sv
`timescale 1ns/10ps
`include "pss_params.svh"

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH = `PSS_FIFO_DEPTH
) (
    input  logic     clk_i,
    input  logic     reset_int_n,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     empty_o,
    output logic     full_o
);

    localparam int ADDR_W = $clog2(DEPTH);

    payload_t        mem [DEPTH];
    payload_t        head_q;
    logic [ADDR_W:0] wr_ptr_q;
    logic [ADDR_W:0] rd_ptr_q;
    logic [ADDR_W:0] rd_ptr_nxt;
    logic            push_do;
    logic            pop_do;

    // extra pointer bit tells full from empty
    assign empty_o = wr_ptr_q == rd_ptr_q;
    assign full_o = (wr_ptr_q[ADDR_W-1:0] == rd_ptr_q[ADDR_W-1:0])
                    && (wr_ptr_q[ADDR_W] != rd_ptr_q[ADDR_W]);

    assign push_do = push_i && !full_o;
    assign pop_do = pop_i && !empty_o;
    assign rd_ptr_nxt = rd_ptr_q + pop_do;

    // ------------------------------
    // pointers
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_int_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_do) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            rd_ptr_q <= rd_ptr_nxt;
        end
    end

    // ------------------------------
    // storage and output register
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (push_do) begin
            mem[wr_ptr_q[ADDR_W-1:0]] <= data_i;
        end
        // new head is the word being written when nothing else is left
        if (push_do && (rd_ptr_nxt == wr_ptr_q)) begin
            head_q <= data_i;
        end else begin
            head_q <= mem[rd_ptr_nxt[ADDR_W-1:0]];
        end
    end

    assign data_o = head_q;

endmodule

//--- test/pss_detector_assertions.sv
`timescale 1ns/10ps

module pss_detector_assertions (
    input logic           clk_i,
    input logic           reset_int_n,
    input logic           sample_push_i,
    input logic           sample_full_i,
    input logic           entry_push_i,
    input logic           entry_full_i,
    input logic           m_valid_i,
    input logic           n_id_2_valid_i,
    input pss_pkg::nid2_t n_id_2_i
);

    // ------------------------------
    // FIFO overflow
    // ------------------------------
    sample_no_overflow: assert property (
        @(posedge clk_i) disable iff (!reset_int_n) sample_push_i |-> !sample_full_i
    ) else $error("sample FIFO pushed while full");

    entry_no_overflow: assert property (
        @(posedge clk_i) disable iff (!reset_int_n) entry_push_i |-> !entry_full_i
    ) else $error("decision FIFO pushed while full");

    // ------------------------------
    // output rules
    // ------------------------------
    nid2_with_sample: assert property (
        @(posedge clk_i) disable iff (!reset_int_n) n_id_2_valid_i |-> m_valid_i
    ) else $error("n_id_2_valid_o high without m_valid_o");

    nid2_in_range: assert property (
        @(posedge clk_i) disable iff (!reset_int_n) n_id_2_valid_i |-> n_id_2_i != 2'd3
    ) else $error("n_id_2_o shows the unused value 3");

    // sync reset, so outputs are quiet one edge later
    quiet_in_reset: assert property (
        @(posedge clk_i) !reset_int_n |=> !m_valid_i && !n_id_2_valid_i
    ) else $error("outputs active while the detector is held in reset");

endmodule

bind pss_detector pss_detector_assertions i_pss_detector_assertions (
    .clk_i          (clk_i),
    .reset_int_n    (reset_int_n),
    .sample_push_i  (sample_valid_i),
    .sample_full_i  (sample_full),
    .entry_push_i   (keep),
    .entry_full_i   (entry_full),
    .m_valid_i      (m_valid_o),
    .n_id_2_valid_i (n_id_2_valid_o),
    .n_id_2_i       (n_id_2_o)
);

//--- test/tb_pss_detector.sv
`timescale 1ns/10ps
`include "pss_params.svh"

module tb_pss_detector;

    localparam int PEAK_MAG = 400;
    localparam int BG_MAG = 10;
    localparam int CLEAR_ROW = 28;
    localparam int DRAIN_TIMEOUT = 100;
    localparam pss_pkg::mode_t SRCH = pss_pkg::MODE_SEARCH;
    localparam pss_pkg::mode_t FIND = pss_pkg::MODE_FIND;
    localparam pss_pkg::mode_t PAUSE = pss_pkg::MODE_PAUSE;

    typedef struct {
        pss_pkg::mode_t     mode;
        pss_pkg::nid2_t     req;
        pss_pkg::corr_mag_t noise;
        logic [2:0]         shift;
        pss_pkg::sample_t   sample;
        pss_pkg::corr_mag_t mag0;
        pss_pkg::corr_mag_t mag1;
        pss_pkg::corr_mag_t mag2;
        logic               exp_hit;
        pss_pkg::nid2_t     exp_nid2;
    } row_t;

    logic                     clk_i;
    logic                     reset_ni;
    logic                     clear_ni;
    pss_pkg::sample_t         sample_i;
    logic                     sample_valid_i;
    pss_pkg::corr_mag_t       corr0_i;
    pss_pkg::corr_mag_t       corr1_i;
    pss_pkg::corr_mag_t       corr2_i;
    logic                     corr_valid_i;
    pss_pkg::mode_t           mode_i;
    pss_pkg::nid2_t           requested_n_id_2_i;
    pss_pkg::corr_mag_t       noise_limit_i;
    logic [2:0]               detection_shift_i;
    pss_pkg::sample_t         m_data_o;
    logic                     m_valid_o;
    pss_pkg::nid2_t           n_id_2_o;
    logic                     n_id_2_valid_o;
    logic [`PSS_COUNT_DW-1:0] peak_count0_o;
    logic [`PSS_COUNT_DW-1:0] peak_count1_o;
    logic [`PSS_COUNT_DW-1:0] peak_count2_o;

    row_t             rows [$];
    pss_pkg::sample_t exp_samples [$];
    pss_pkg::sample_t got_samples [$];
    pss_pkg::nid2_t   exp_nid2 [$];
    pss_pkg::nid2_t   got_nid2 [$];
    logic [31:0]      lfsr;
    int               win [3][`PSS_WINDOW_LEN];
    int               exp_cnt [3];
    int               dec_count;
    int               mismatches;
    int               other_errors;
    bit               drained;

    pss_detector i_pss_detector (
        .clk_i              (clk_i),
        .reset_ni           (reset_ni),
        .clear_ni           (clear_ni),
        .sample_i           (sample_i),
        .sample_valid_i     (sample_valid_i),
        .corr0_i            (corr0_i),
        .corr1_i            (corr1_i),
        .corr2_i            (corr2_i),
        .corr_valid_i       (corr_valid_i),
        .mode_i             (mode_i),
        .requested_n_id_2_i (requested_n_id_2_i),
        .noise_limit_i      (noise_limit_i),
        .detection_shift_i  (detection_shift_i),
        .m_data_o           (m_data_o),
        .m_valid_o          (m_valid_o),
        .n_id_2_o           (n_id_2_o),
        .n_id_2_valid_o     (n_id_2_valid_o),
        .peak_count0_o      (peak_count0_o),
        .peak_count1_o      (peak_count1_o),
        .peak_count2_o      (peak_count2_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        if (m_valid_o) begin
            got_samples.push_back(m_data_o);
        end
        if (n_id_2_valid_o) begin
            got_nid2.push_back(n_id_2_o);
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    task automatic add_row(input pss_pkg::mode_t mode, input pss_pkg::nid2_t req,
                           input pss_pkg::corr_mag_t noise, input logic [2:0] shift,
                           input pss_pkg::corr_mag_t m0, input pss_pkg::corr_mag_t m1,
                           input pss_pkg::corr_mag_t m2, input logic hit,
                           input pss_pkg::nid2_t nid2);
        row_t r;
        r.mode = mode;
        r.req = req;
        r.noise = noise;
        r.shift = shift;
        r.mag0 = m0;
        r.mag1 = m1;
        r.mag2 = m2;
        r.exp_hit = hit;
        r.exp_nid2 = nid2;
        for (int b = 0; b < 32; b++) begin
            lfsr = lfsr_next(lfsr);
            r.sample[b] = lfsr[0];
        end
        rows.push_back(r);
    endtask

    // ------------------------------
    // stimulus table
    // ------------------------------
    task automatic build_rows();
        // warm-up after reset
        add_row(SRCH, 0, 50, 1, PEAK_MAG, BG_MAG, BG_MAG, 1, 0);
        add_row(SRCH, 0, 50, 1, BG_MAG, PEAK_MAG, BG_MAG, 1, 1);
        add_row(SRCH, 0, 50, 1, BG_MAG, BG_MAG, BG_MAG, 0, 0);
        add_row(SRCH, 0, 50, 1, BG_MAG, BG_MAG, PEAK_MAG, 1, 2);
        add_row(SRCH, 0, 50, 1, PEAK_MAG, PEAK_MAG, BG_MAG, 0, 0);
        repeat (3) add_row(SRCH, 0, 50, 1, BG_MAG, BG_MAG, BG_MAG, 0, 0);
        // search
        add_row(SRCH, 0, 50, 1, BG_MAG, PEAK_MAG, BG_MAG, 1, 1);
        add_row(SRCH, 0, 50, 1, BG_MAG, BG_MAG, BG_MAG, 0, 0);
        add_row(SRCH, 0, 50, 1, BG_MAG, BG_MAG, PEAK_MAG, 1, 2);
        add_row(SRCH, 0, 50, 1, PEAK_MAG, BG_MAG, PEAK_MAG, 0, 0);
        add_row(SRCH, 0, 500, 1, PEAK_MAG, BG_MAG, BG_MAG, 0, 0);
        add_row(SRCH, 0, 50, 1, BG_MAG, BG_MAG, BG_MAG, 0, 0);
        // find mode with requested index 2
        add_row(FIND, 2, 50, 1, BG_MAG, BG_MAG, PEAK_MAG, 1, 2);
        add_row(FIND, 2, 50, 1, PEAK_MAG, BG_MAG, BG_MAG, 0, 0);
        add_row(FIND, 2, 50, 1, BG_MAG, BG_MAG, BG_MAG, 0, 0);
        add_row(FIND, 2, 50, 1, BG_MAG, PEAK_MAG, BG_MAG, 0, 0);
        add_row(FIND, 2, 50, 1, BG_MAG, BG_MAG, PEAK_MAG, 1, 2);
        // pause
        add_row(PAUSE, 0, 50, 1, PEAK_MAG, BG_MAG, BG_MAG, 0, 0);
        add_row(PAUSE, 0, 50, 1, BG_MAG, PEAK_MAG, PEAK_MAG, 0, 0);
        add_row(PAUSE, 0, 50, 1, PEAK_MAG, PEAK_MAG, PEAK_MAG, 0, 0);
        add_row(SRCH, 0, 50, 1, BG_MAG, BG_MAG, BG_MAG, 0, 0);
        add_row(SRCH, 0, 50, 1, BG_MAG, PEAK_MAG, BG_MAG, 1, 1);
        repeat (4) add_row(SRCH, 0, 50, 1, 0, 0, 0, 0, 0);
        // clear pulses before this row and warm-up starts again
        add_row(SRCH, 0, 50, 1, PEAK_MAG, BG_MAG, BG_MAG, 1, 0);
        add_row(SRCH, 0, 50, 1, BG_MAG, BG_MAG, PEAK_MAG, 1, 2);
        repeat (6) add_row(SRCH, 0, 50, 1, BG_MAG, BG_MAG, BG_MAG, 0, 0);
        add_row(SRCH, 0, 50, 1, BG_MAG, PEAK_MAG, BG_MAG, 1, 1);
        // above the noise limit but not above the shifted average
        add_row(SRCH, 0, 50, 2, BG_MAG, BG_MAG, 200, 0, 0);
        repeat (4) add_row(SRCH, 0, 50, 1, 0, 0, 0, 0, 0);
    endtask

    // ------------------------------
    // reference model
    // ------------------------------
    task automatic clear_model();
        for (int c = 0; c < 3; c++) begin
            for (int k = 0; k < `PSS_WINDOW_LEN; k++) begin
                win[c][k] = 0;
            end
        end
        dec_count = 0;
    endtask

    task automatic predict_row(input int idx_row, input row_t r);
        int mag [3];
        int sum;
        int thr;
        bit enable;
        bit peak;
        int npk;
        int idx;
        bit hit;
        mag[0] = r.mag0;
        mag[1] = r.mag1;
        mag[2] = r.mag2;
        enable = (r.mode == pss_pkg::MODE_SEARCH) || (r.mode == pss_pkg::MODE_FIND);
        npk = 0;
        idx = 0;
        for (int c = 0; c < 3; c++) begin
            sum = 0;
            for (int k = 0; k < `PSS_WINDOW_LEN; k++) begin
                sum += win[c][k];
            end
            // average of the earlier values only
            thr = (sum >> `PSS_WINDOW_LOG2) << r.shift;
            peak = enable && (mag[c] > r.noise) && (mag[c] > thr);
            for (int k = `PSS_WINDOW_LEN - 1; k > 0; k--) begin
                win[c][k] = win[c][k-1];
            end
            win[c][0] = mag[c];
            if (peak) begin
                npk++;
                idx = c;
                exp_cnt[c]++;
            end
        end
        case (r.mode)
            pss_pkg::MODE_SEARCH: hit = npk == 1;
            pss_pkg::MODE_FIND: hit = (npk == 1) && (idx == r.req);
            default: hit = 1'b0;
        endcase
        assert (hit == r.exp_hit && (!hit || idx == r.exp_nid2)) else begin
            other_errors++;
            $display("row %0d: table expects hit %0b nid2 %0d, model gives hit %0b nid2 %0d",
                     idx_row, r.exp_hit, r.exp_nid2, hit, idx);
        end
        if (dec_count >= `PSS_WARMUP_LEN && hit) begin
            exp_nid2.push_back(pss_pkg::nid2_t'(idx));
        end
        dec_count++;
    endtask

    // ------------------------------
    // drive and check
    // ------------------------------
    task automatic idle(input int n);
        sample_valid_i = 1'b0;
        corr_valid_i = 1'b0;
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic drive_row(input row_t r);
        mode_i = r.mode;
        requested_n_id_2_i = r.req;
        noise_limit_i = r.noise;
        detection_shift_i = r.shift;
        sample_i = r.sample;
        corr0_i = r.mag0;
        corr1_i = r.mag1;
        corr2_i = r.mag2;
        sample_valid_i = 1'b1;
        corr_valid_i = 1'b1;
        exp_samples.push_back(r.sample);
        @(posedge clk_i);
        #1;
        sample_valid_i = 1'b0;
        corr_valid_i = 1'b0;
    endtask

    task automatic finish_run();
        $display("%0d mismatches, %0d other errors, %0d samples, %0d decisions expected",
                 mismatches, other_errors, exp_samples.size(), exp_nid2.size());
        if (mismatches == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic wait_drain(output bit done);
        int cycles;
        cycles = 0;
        while ((got_samples.size() < exp_samples.size() || got_nid2.size() < exp_nid2.size())
               && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        done = (got_samples.size() >= exp_samples.size())
               && (got_nid2.size() >= exp_nid2.size());
        if (!done) begin
            other_errors++;
            $display("timeout at %0t: output FIFOs did not drain within %0d cycles",
                     $time, DRAIN_TIMEOUT);
        end
    endtask

    task automatic check_counts();
        logic [`PSS_COUNT_DW-1:0] got [3];
        got[0] = peak_count0_o;
        got[1] = peak_count1_o;
        got[2] = peak_count2_o;
        for (int i = 0; i < 3; i++) begin
            assert (got[i] == exp_cnt[i]) else begin
                mismatches++;
                $display("Mismatch at %0t: peak_count%0d_o got %0d expected %0d",
                         $time, i, got[i], exp_cnt[i]);
            end
        end
    endtask

    task automatic compare_outputs();
        assert (got_samples.size() == exp_samples.size()) else begin
            mismatches++;
            $display("Mismatch at %0t: m_valid_o count got %0d expected %0d",
                     $time, got_samples.size(), exp_samples.size());
        end
        for (int i = 0; i < got_samples.size() && i < exp_samples.size(); i++) begin
            assert (got_samples[i] == exp_samples[i]) else begin
                mismatches++;
                $display("Mismatch at %0t: m_data_o[%0d] got %h expected %h",
                         $time, i, got_samples[i], exp_samples[i]);
            end
        end
        assert (got_nid2.size() == exp_nid2.size()) else begin
            mismatches++;
            $display("Mismatch at %0t: n_id_2_valid_o count got %0d expected %0d",
                     $time, got_nid2.size(), exp_nid2.size());
        end
        for (int i = 0; i < got_nid2.size() && i < exp_nid2.size(); i++) begin
            assert (got_nid2[i] == exp_nid2[i]) else begin
                mismatches++;
                $display("Mismatch at %0t: n_id_2_o[%0d] got %0d expected %0d",
                         $time, i, got_nid2[i], exp_nid2[i]);
            end
        end
    endtask

    initial begin
        reset_ni = 1'b0;
        clear_ni = 1'b1;
        sample_i = '0;
        sample_valid_i = 1'b0;
        corr0_i = '0;
        corr1_i = '0;
        corr2_i = '0;
        corr_valid_i = 1'b0;
        mode_i = pss_pkg::MODE_SEARCH;
        requested_n_id_2_i = '0;
        noise_limit_i = '0;
        detection_shift_i = '0;
        mismatches = 0;
        other_errors = 0;
        drained = 1'b1;
        exp_cnt = '{0, 0, 0};
        lfsr = 32'he93e_3abf;
        build_rows();
        clear_model();

        repeat (4) @(posedge clk_i);
        #1;
        reset_ni = 1'b1;
        // corr_en follows mode one cycle late
        idle(2);

        for (int k = 0; k < rows.size(); k++) begin
            if (k == CLEAR_ROW) begin
                wait_drain(drained);
                if (!drained) begin
                    break;
                end
                check_counts();
                clear_ni = 1'b0;
                idle(2);
                clear_ni = 1'b1;
                clear_model();
                idle(2);
                check_counts();
            end
            if (rows[k].mode != mode_i) begin
                idle(2);
                mode_i = rows[k].mode;
                idle(2);
            end
            predict_row(k, rows[k]);
            drive_row(rows[k]);
        end

        if (drained) begin
            wait_drain(drained);
        end
        if (drained) begin
            idle(4);
            check_counts();
            compare_outputs();
        end
        finish_run();
    end

endmodule
